// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

	//////////////////////////////
	// Datapath sizes
	//////////////////////////////

	// Operand, result and register width
	localparam int data_w = 32;

	// Register index and register count
	localparam int reg_addr_w = 4;
	localparam int num_regs = 16;

	// Instruction fields
	localparam int op_w = 4;
	localparam int imm_w = 16;

	// Shift amount taken from the low bits of operand B
	localparam int shamt_w = 5;

	//////////////////////////////
	// Operand selects
	//////////////////////////////

	localparam int sel_w = 2;

	// Register file read data
	localparam logic [sel_w-1:0] sel_rf = 2'd0;
	// Sign-extended immediate, operand B only
	localparam logic [sel_w-1:0] sel_imm = 2'd1;
	// ALU output of the instruction in execute
	localparam logic [sel_w-1:0] sel_ex_forw = 2'd2;
	// Writeback register
	localparam logic [sel_w-1:0] sel_wb_forw = 2'd3;

	//////////////////////////////
	// Opcodes
	//////////////////////////////

	// Register-register forms
	localparam logic [op_w-1:0] op_add = 4'd0;
	localparam logic [op_w-1:0] op_sub = 4'd1;
	localparam logic [op_w-1:0] op_and = 4'd2;
	localparam logic [op_w-1:0] op_or = 4'd3;
	localparam logic [op_w-1:0] op_xor = 4'd4;
	localparam logic [op_w-1:0] op_sll = 4'd5;
	localparam logic [op_w-1:0] op_slt = 4'd6;

	// Immediate forms
	localparam logic [op_w-1:0] op_addi = 4'd8;
	localparam logic [op_w-1:0] op_andi = 4'd9;
	localparam logic [op_w-1:0] op_ori = 4'd10;

	// Set in every immediate opcode
	localparam int op_imm_bit = 3;

	// One instruction word, two views sharing op, rd and ra
	typedef union packed {
		struct packed {
			logic [op_w-1:0] op;
			logic [reg_addr_w-1:0] rd;
			logic [reg_addr_w-1:0] ra;
			logic [reg_addr_w-1:0] rb;
			logic [imm_w-1:0] rsvd;
		} r;
		struct packed {
			logic [op_w-1:0] op;
			logic [reg_addr_w-1:0] rd;
			logic [reg_addr_w-1:0] ra;
			// Unused, sits where rb is in the register form
			logic [reg_addr_w-1:0] rsvd;
			logic [imm_w-1:0] imm;
		} i;
	} instr_t;

endpackage

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
	input  logic clk,
	input  logic arst_n,

	// Read port A
	input  logic [reg_addr_w-1:0] ra_addr,
	output logic [data_w-1:0] rf_dataa,

	// Read port B
	input  logic [reg_addr_w-1:0] rb_addr,
	output logic [data_w-1:0] rf_datab,

	// Write port, fed from writeback
	input  logic we,
	input  logic [reg_addr_w-1:0] wr_addr,
	input  logic [data_w-1:0] wr_data
);

	// Register storage
	logic [data_w-1:0] regs [num_regs];

	//////////////////////////////
	// Write port
	//////////////////////////////

	// Writes to r0 are dropped so it stays zero
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////

	// Asynchronous reads
	// r0 holds its reset value of zero
	always_comb begin
		rf_dataa = regs[ra_addr];
	end

	always_comb begin
		rf_datab = regs[rb_addr];
	end

endmodule

`default_nettype wire

// File: hdl/decode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl import core_pkg::*; (
	input  logic clk,
	input  logic arst_n,

	// Instruction input
	input  logic instr_valid,
	input  instr_t instr,
	input  logic stall,

	// Writeback stage destination, for hazard checks
	input  logic wb_valid,
	input  logic [reg_addr_w-1:0] wb_rd,

	// Register file read addresses
	output logic [reg_addr_w-1:0] ra_addr,
	output logic [reg_addr_w-1:0] rb_addr,

	// Operand selection
	output logic [data_w-1:0] simm,
	output logic [sel_w-1:0] sel_a,
	output logic [sel_w-1:0] sel_b,

	// Pipeline freezes
	output logic id_freeze,
	output logic ex_freeze,

	// Execute stage control
	output logic [op_w-1:0] ex_op,
	output logic [reg_addr_w-1:0] ex_rd,
	output logic ex_valid
);

	// Immediate form flag
	logic is_imm;

	// Source register matches against later stages
	logic a_hit_ex;
	logic a_hit_wb;
	logic b_hit_ex;
	logic b_hit_wb;

	//////////////////////////////
	// Freeze generation
	//////////////////////////////

	// Stall holds everything
	assign ex_freeze = stall;
	// Decode also freezes on an empty slot
	assign id_freeze = stall | ~instr_valid;

	//////////////////////////////
	// Field decode
	//////////////////////////////

	// Opcode, rd and ra sit at the same place in both views
	assign is_imm = instr.r.op[op_imm_bit];
	assign ra_addr = instr.r.ra;
	// Meaningless for the immediate form, B is then steered to simm
	assign rb_addr = instr.r.rb;

	// Sign extension of the 16-bit immediate
	assign simm = {{(data_w-imm_w){instr.i.imm[imm_w-1]}}, instr.i.imm};

	//////////////////////////////
	// Forwarding selects
	//////////////////////////////

	// r0 never forwards, it reads as zero from the register file
	assign a_hit_ex = ex_valid && (ra_addr == ex_rd) && (ra_addr != '0);
	assign a_hit_wb = wb_valid && (ra_addr == wb_rd) && (ra_addr != '0);
	assign b_hit_ex = ex_valid && (rb_addr == ex_rd) && (rb_addr != '0);
	assign b_hit_wb = wb_valid && (rb_addr == wb_rd) && (rb_addr != '0);

	// Execute is the younger result, so it wins over writeback
	always_comb begin
		if (a_hit_ex) begin
			sel_a = sel_ex_forw;
		end else if (a_hit_wb) begin
			sel_a = sel_wb_forw;
		end else begin
			sel_a = sel_rf;
		end
	end

	// Immediate form overrides any register match on B
	always_comb begin
		if (is_imm) begin
			sel_b = sel_imm;
		end else if (b_hit_ex) begin
			sel_b = sel_ex_forw;
		end else if (b_hit_wb) begin
			sel_b = sel_wb_forw;
		end else begin
			sel_b = sel_rf;
		end
	end

	//////////////////////////////
	// Execute stage control
	//////////////////////////////

	// An empty decode slot enters execute as a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
			ex_op <= op_add;
			ex_rd <= '0;
		end else if (!ex_freeze) begin
			ex_valid <= !id_freeze;
			ex_op <= instr.r.op;
			ex_rd <= instr.r.rd;
		end
	end

endmodule

`default_nettype wire

// File: hdl/operand_muxes.sv
`timescale 1ns/1ps
`default_nettype none

module operand_muxes import core_pkg::*; (
	input  logic clk,
	input  logic arst_n,

	// Pipeline freezes
	input  logic id_freeze,
	input  logic ex_freeze,

	// Operand sources
	input  logic [data_w-1:0] rf_dataa,
	input  logic [data_w-1:0] rf_datab,
	input  logic [data_w-1:0] ex_forw,
	input  logic [data_w-1:0] wb_forw,
	input  logic [data_w-1:0] simm,

	// Selects from decode
	input  logic [sel_w-1:0] sel_a,
	input  logic [sel_w-1:0] sel_b,

	// Execute stage operands
	output logic [data_w-1:0] operand_a,
	output logic [data_w-1:0] operand_b
);

	// Selected values ahead of the operand registers
	logic [data_w-1:0] muxed_a;
	logic [data_w-1:0] muxed_b;

	// Operands already captured during a decode freeze
	// Both operands freeze together, so one flag covers both
	logic saved;

	//////////////////////////////
	// Forwarding muxes
	//////////////////////////////

	// A has no immediate source
	always_comb begin
		case (sel_a)
			sel_ex_forw: muxed_a = ex_forw;
			sel_wb_forw: muxed_a = wb_forw;
			default:     muxed_a = rf_dataa;
		endcase
	end

	always_comb begin
		case (sel_b)
			sel_imm:     muxed_b = simm;
			sel_ex_forw: muxed_b = ex_forw;
			sel_wb_forw: muxed_b = wb_forw;
			default:     muxed_b = rf_datab;
		endcase
	end

	//////////////////////////////
	// Operand registers
	//////////////////////////////

	// Both freezes low loads a new instruction and releases the hold
	// First edge of a decode-only freeze captures once, then holds
	// Execute freeze holds everything
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			operand_a <= '0;
			operand_b <= '0;
			saved <= 1'b0;
		end else if (!ex_freeze && !id_freeze) begin
			operand_a <= muxed_a;
			operand_b <= muxed_b;
			saved <= 1'b0;
		end else if (!ex_freeze && !saved) begin
			operand_a <= muxed_a;
			operand_b <= muxed_b;
			saved <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu import core_pkg::*; (
	input  logic clk,
	input  logic arst_n,

	// Pipeline hold
	input  logic ex_freeze,
	input  logic stall,

	// Execute stage inputs
	input  logic [data_w-1:0] operand_a,
	input  logic [data_w-1:0] operand_b,
	input  logic [op_w-1:0] ex_op,
	input  logic [reg_addr_w-1:0] ex_rd,
	input  logic ex_valid,

	// ALU result, also the execute forwarding source
	output logic [data_w-1:0] ex_forw,

	// Writeback stage
	output logic wb_valid,
	output logic [reg_addr_w-1:0] wb_rd,
	output logic [data_w-1:0] wb_data
);

	// Writeback valid ahead of the stall gate
	logic wb_valid_q;

	//////////////////////////////
	// ALU
	//////////////////////////////

	// Immediate opcodes share the register-form datapath
	// Undefined opcodes give zero
	always_comb begin
		case (ex_op)
			op_add, op_addi: ex_forw = operand_a + operand_b;
			op_sub:          ex_forw = operand_a - operand_b;
			op_and, op_andi: ex_forw = operand_a & operand_b;
			op_or, op_ori:   ex_forw = operand_a | operand_b;
			op_xor:          ex_forw = operand_a ^ operand_b;
			// Shift amount from the low bits of B
			op_sll:          ex_forw = operand_a << operand_b[shamt_w-1:0];
			// Signed compare, result 1 or 0
			op_slt: begin
				ex_forw = {{(data_w-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
			end
			default:         ex_forw = '0;
		endcase
	end

	//////////////////////////////
	// Writeback register
	//////////////////////////////

	// Bubbles pass through as wb_valid low
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid_q <= 1'b0;
			wb_rd <= '0;
			wb_data <= '0;
		end else if (!ex_freeze) begin
			wb_valid_q <= ex_valid;
			wb_rd <= ex_rd;
			wb_data <= ex_forw;
		end
	end

	// Result port and register write both idle under stall
	assign wb_valid = wb_valid_q & ~stall;

endmodule

`default_nettype wire

// File: hdl/int_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module int_pipe_top import core_pkg::*; (
	input  logic clk,
	input  logic arst_n,

	// Instruction input, accepted when valid and not stalled
	input  logic instr_valid,
	input  instr_t instr,
	input  logic stall,

	// Result port, straight from writeback
	output logic res_valid,
	output logic [reg_addr_w-1:0] res_rd,
	output logic [data_w-1:0] res_data
);

	// Register file reads
	logic [reg_addr_w-1:0] ra_addr;
	logic [reg_addr_w-1:0] rb_addr;
	logic [data_w-1:0] rf_dataa;
	logic [data_w-1:0] rf_datab;

	// Decode to operand muxes
	logic [data_w-1:0] simm;
	logic [sel_w-1:0] sel_a;
	logic [sel_w-1:0] sel_b;
	logic id_freeze;
	logic ex_freeze;

	// Execute stage
	logic [data_w-1:0] operand_a;
	logic [data_w-1:0] operand_b;
	logic [data_w-1:0] ex_forw;
	logic [op_w-1:0] ex_op;
	logic [reg_addr_w-1:0] ex_rd;
	logic ex_valid;

	// Decode, hazard detection and execute control
	decode_ctrl u_decode_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.stall       (stall),
		.wb_valid    (res_valid),
		.wb_rd       (res_rd),
		.ra_addr     (ra_addr),
		.rb_addr     (rb_addr),
		.simm        (simm),
		.sel_a       (sel_a),
		.sel_b       (sel_b),
		.id_freeze   (id_freeze),
		.ex_freeze   (ex_freeze),
		.ex_op       (ex_op),
		.ex_rd       (ex_rd),
		.ex_valid    (ex_valid)
	);

	// Written from writeback, the gated valid acts as write enable
	reg_file u_reg_file (
		.clk      (clk),
		.arst_n   (arst_n),
		.ra_addr  (ra_addr),
		.rb_addr  (rb_addr),
		.rf_dataa (rf_dataa),
		.rf_datab (rf_datab),
		.we       (res_valid),
		.wr_addr  (res_rd),
		.wr_data  (res_data)
	);

	// Writeback data doubles as the writeback forwarding source
	operand_muxes u_operand_muxes (
		.clk       (clk),
		.arst_n    (arst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_dataa  (rf_dataa),
		.rf_datab  (rf_datab),
		.ex_forw   (ex_forw),
		.wb_forw   (res_data),
		.simm      (simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	// ALU and writeback stage
	exec_alu u_exec_alu (
		.clk       (clk),
		.arst_n    (arst_n),
		.ex_freeze (ex_freeze),
		.stall     (stall),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_op     (ex_op),
		.ex_rd     (ex_rd),
		.ex_valid  (ex_valid),
		.ex_forw   (ex_forw),
		.wb_valid  (res_valid),
		.wb_rd     (res_rd),
		.wb_data   (res_data)
	);

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk,
	output logic arst_n
);

	// 40 ns period, first rising edge at 20 ns
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset low for 5 cycles
	// Released 2 ns after an edge, in step with the stimulus
	initial begin
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		#2 arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: sim/tb_int_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_int_pipe import core_pkg::*; ();

	//////////////////////////////
	// Run length
	//////////////////////////////

	// Instructions issued over all tests
	// reset 15, preload 15, opcodes 40, chains 62, stall 40, gaps 40, latency 10
	localparam int n_instr = 222;
	localparam int clk_period = 40;
	localparam int wd_cycles = n_instr * 40 + 200;

	logic clk;
	logic arst_n;
	logic instr_valid;
	instr_t instr;
	logic stall;
	logic res_valid;
	logic [reg_addr_w-1:0] res_rd;
	logic [data_w-1:0] res_data;

	// Reference register file, updated at issue
	logic [data_w-1:0] model_regs [num_regs];

	// Expected results in issue order, with acceptance time
	logic [reg_addr_w-1:0] exp_rd_q [$];
	logic [data_w-1:0] exp_data_q [$];
	time exp_time_q [$];

	int errors = 0;
	int checks = 0;
	logic [31:0] rng = 32'hebc1;
	logic stall_mode = 1'b0;
	logic check_latency = 1'b0;

	clk_gen u_clk_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	int_pipe_top dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.stall       (stall),
		.res_valid   (res_valid),
		.res_rd      (res_rd),
		.res_data    (res_data)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// xorshift32 step
	function automatic logic [31:0] rand32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [reg_addr_w-1:0] rand_reg();
		return reg_addr_w'(rand32());
	endfunction

	// Index 0 to 6 gives the register forms, 7 to 9 the immediate forms
	function automatic logic [op_w-1:0] op_from_index(input logic [31:0] idx);
		logic [op_w-1:0] op;
		case (idx)
			32'd1: op = op_sub;
			32'd2: op = op_and;
			32'd3: op = op_or;
			32'd4: op = op_xor;
			32'd5: op = op_sll;
			32'd6: op = op_slt;
			32'd7: op = op_addi;
			32'd8: op = op_andi;
			32'd9: op = op_ori;
			default: op = op_add;
		endcase
		return op;
	endfunction

	// Register forms only when immediates are not wanted
	function automatic logic [op_w-1:0] rand_op(input logic allow_imm);
		logic [31:0] r;
		r = allow_imm ? rand32() % 32'd10 : rand32() % 32'd7;
		return op_from_index(r);
	endfunction

	// Expected ALU result
	function automatic logic [data_w-1:0] expect_result(input logic [op_w-1:0] op,
			input logic [data_w-1:0] a, input logic [data_w-1:0] b);
		logic [data_w-1:0] r;
		case (op)
			op_add, op_addi: r = a + b;
			op_sub: r = a - b;
			op_and, op_andi: r = a & b;
			op_or, op_ori: r = a | b;
			op_xor: r = a ^ b;
			op_sll: r = a << b[4:0];
			op_slt: begin
				// Differing signs decide alone, else plain magnitude compare
				if (a[31] != b[31]) begin
					r = {31'd0, a[31]};
				end else begin
					r = {31'd0, a < b};
				end
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic instr_t build_instr(input logic [op_w-1:0] op,
			input logic [reg_addr_w-1:0] rd, input logic [reg_addr_w-1:0] ra,
			input logic [reg_addr_w-1:0] rb, input logic [imm_w-1:0] imm);
		instr_t w;
		if (op[op_imm_bit]) begin
			w.i.op = op;
			w.i.rd = rd;
			w.i.ra = ra;
			w.i.rsvd = '0;
			w.i.imm = imm;
		end else begin
			w.r.op = op;
			w.r.rd = rd;
			w.r.ra = ra;
			w.r.rb = rb;
			w.r.rsvd = '0;
		end
		return w;
	endfunction

	// Presents one instruction until accepted, then logs the expected result
	// Random stall only in stall mode
	task automatic issue(input logic [op_w-1:0] op, input logic [reg_addr_w-1:0] rd,
			input logic [reg_addr_w-1:0] ra, input logic [reg_addr_w-1:0] rb,
			input logic [imm_w-1:0] imm);
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		logic taken;
		time t_acc;
		a = model_regs[ra];
		b = op[op_imm_bit] ? {{(data_w-imm_w){imm[imm_w-1]}}, imm} : model_regs[rb];
		taken = 1'b0;
		t_acc = 0;
		while (!taken) begin
			stall = stall_mode && ((rand32() & 32'h3) == 32'h0);
			instr_valid = 1'b1;
			instr = build_instr(op, rd, ra, rb, imm);
			@(posedge clk);
			t_acc = $time;
			taken = !stall;
			#2;
		end
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(expect_result(op, a, b));
		exp_time_q.push_back(t_acc);
		// r0 keeps zero in the model
		if (rd != '0) begin
			model_regs[rd] = expect_result(op, a, b);
		end
		instr_valid = 1'b0;
		stall = 1'b0;
	endtask

	// Empty slots, with junk on the instruction bus
	task automatic idle(input int n);
		repeat (n) begin
			instr_valid = 1'b0;
			instr = rand32();
			stall = 1'b0;
			@(posedge clk);
			#2;
		end
	endtask

	// Wait for every outstanding result, bounded
	task automatic drain();
		int n;
		n = 0;
		while (exp_rd_q.size() != 0 && n < 20) begin
			idle(1);
			n++;
		end
		checks++;
		assert (exp_rd_q.size() == 0) else begin
			errors++;
			$display("At %0t, %0d results never came out", $time, exp_rd_q.size());
		end
		idle(2);
	endtask

	//////////////////////////////
	// Result monitor
	//////////////////////////////

	// Sampled at the falling edge, away from both drive and capture
	always @(negedge clk) begin : monitor
		logic [reg_addr_w-1:0] erd;
		logic [data_w-1:0] edata;
		time etime;
		if (!arst_n || stall) begin
			checks++;
			assert (!res_valid) else begin
				errors++;
				$display("Fail %0t: res_valid high during reset or stall", $time);
			end
		end
		if (res_valid) begin
			checks++;
			assert (exp_rd_q.size() != 0) else begin
				errors++;
				$display("At %0t a result came out with no instruction outstanding", $time);
			end
			if (exp_rd_q.size() != 0) begin
				erd = exp_rd_q.pop_front();
				edata = exp_data_q.pop_front();
				etime = exp_time_q.pop_front();
				assert (res_rd == erd && res_data == edata) else begin
					errors++;
					$display("Fail %0t: got r%0d = %h, expected r%0d = %h",
						$time, res_rd, res_data, erd, edata);
				end
				// Acceptance edge plus one and a half periods
				if (check_latency) begin
					checks++;
					assert ($time - etime == 60) else begin
						errors++;
						$display("Fail %0t: latency %0t ns, expected 60 ns",
							$time, $time - etime);
					end
				end
			end
		end
	end

	//////////////////////////////
	// Tests
	//////////////////////////////

	// Registers read back zero after reset
	task automatic test_reset();
		idle(3);
		for (int y = 1; y < num_regs; y++) begin
			issue(op_add, 4'(y), 4'd0, 4'(y), 16'd0);
		end
		drain();
	endtask

	// Two empty slots after each instruction keep forwarding out of play
	// Four rounds over all ten opcodes
	task automatic test_opcodes();
		for (int y = 1; y < num_regs; y++) begin
			issue(op_addi, 4'(y), 4'd0, 4'd0, imm_w'(rand32()));
			idle(2);
		end
		for (int k = 0; k < 40; k++) begin
			issue(op_from_index(k % 10), rand_reg(), rand_reg(), rand_reg(),
				imm_w'(rand32()));
			idle(2);
		end
		drain();
	endtask

	// gap 0 uses the execute path, gap 1 the writeback path
	task automatic run_chain(input int gap, input logic dep_a, input logic dep_b);
		logic [reg_addr_w-1:0] prev;
		logic [reg_addr_w-1:0] rd;
		prev = rand_reg();
		for (int k = 0; k < 12; k++) begin
			rd = rand_reg();
			issue(rand_op(!dep_b), rd, dep_a ? prev : rand_reg(), dep_b ? prev : rand_reg(),
				imm_w'(rand32()));
			idle(gap);
			prev = rd;
		end
		drain();
	endtask

	task automatic test_forwarding();
		run_chain(0, 1'b1, 1'b0);
		run_chain(0, 1'b0, 1'b1);
		run_chain(1, 1'b1, 1'b0);
		run_chain(1, 1'b0, 1'b1);
		run_chain(0, 1'b1, 1'b1);
		// Result aimed at r0 must not forward into the next read
		issue(op_addi, 4'd0, 4'd0, 4'd0, 16'h1234);
		issue(op_add, 4'd5, 4'd0, 4'd0, 16'd0);
		drain();
	endtask

	// Dependent stream with stall pulses
	task automatic test_stall();
		logic [reg_addr_w-1:0] prev;
		logic [reg_addr_w-1:0] rd;
		prev = rand_reg();
		stall_mode = 1'b1;
		for (int k = 0; k < 40; k++) begin
			rd = rand_reg();
			issue(rand_op(1'b1), rd, prev, rand_reg(), imm_w'(rand32()));
			prev = rd;
		end
		stall_mode = 1'b0;
		drain();
	endtask

	// Random empty slots exercise the operand hold after a decode freeze
	task automatic test_gaps();
		logic [reg_addr_w-1:0] prev;
		logic [reg_addr_w-1:0] rd;
		prev = rand_reg();
		for (int k = 0; k < 40; k++) begin
			rd = rand_reg();
			issue(rand_op(1'b0), rd, prev, rand32() % 2 == 0 ? prev : rand_reg(), 16'd0);
			idle(int'(rand32() % 32'd3));
			prev = rd;
		end
		drain();
	endtask

	task automatic test_latency();
		check_latency = 1'b1;
		for (int k = 0; k < 10; k++) begin
			issue(rand_op(1'b1), rand_reg(), rand_reg(), rand_reg(), imm_w'(rand32()));
			idle(int'(rand32() % 32'd2));
		end
		drain();
		check_latency = 1'b0;
	endtask

	//////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////

	initial begin
		instr_valid = 1'b0;
		instr = '0;
		stall = 1'b0;
		for (int y = 0; y < num_regs; y++) begin
			model_regs[y] = '0;
		end
		// Reset release falls 2 ns after an edge
		@(posedge arst_n);
		test_reset();
		test_opcodes();
		test_forwarding();
		test_stall();
		test_gaps();
		test_latency();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(wd_cycles * clk_period);
		$display("Timeout: the tests did not finish within %0d cycles", wd_cycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
hdl/core_pkg.sv
hdl/reg_file.sv
hdl/decode_ctrl.sv
hdl/operand_muxes.sv
hdl/exec_alu.sv
hdl/int_pipe_top.sv
sim/clk_gen.sv
sim/tb_int_pipe.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module tb_int_pipe -o tb_int_pipe

out=$(./obj_dir/tb_int_pipe)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1
